//--- Makefile
SRCS := $(shell cat all.f)

obj_dir/Vtb_eeprom: all.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_eeprom -f all.f

run: obj_dir/Vtb_eeprom
	./obj_dir/Vtb_eeprom 2>&1 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log || ! grep -q "Simulation PASSED" sim.log; then \
		echo "run failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- all.f
eeprom_pkg.sv
i2c_byte_if.sv
i2c_bit_engine.sv
i2c_byte_shifter.sv
eeprom_ctrl.sv
eeprom_i2c_top.sv
eeprom_model.sv
eeprom_chk.sv
tb_eeprom.sv

//--- eeprom_chk.sv
`timescale 1ns/1ps

module eeprom_chk import eeprom_pkg::*;
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     done,
    input  logic     nack,
    input  logic     busy,
    input  logic     scl,
    input  logic     sda_pull,
    input  bit_cmd_t bit_cmd
);

    a_done_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_nack_with_done: assert property (@(posedge CLK) disable iff (RESET)
        $rose(nack) |-> done)
        else $error("nack was set without done");

    // sda only moves under a high scl for start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (bit_cmd != BIT_START) && (bit_cmd != BIT_STOP))
        |-> $stable(sda_pull))
        else $error("sda_pull changed while scl was high");

    a_idle_at_done: assert property (@(posedge CLK) disable iff (RESET)
        done |-> !busy)
        else $error("busy was high in the done cycle");

endmodule

bind eeprom_i2c_top eeprom_chk u_chk (
    .CLK      (CLK),
    .RESET    (RESET),
    .done     (done),
    .nack     (nack),
    .busy     (busy),
    .scl      (scl),
    .sda_pull (sda_pull),
    .bit_cmd  (u_bit.cur_cmd)
);

//--- eeprom_ctrl.sv
`timescale 1ns/1ps

module eeprom_ctrl import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        done,
    output logic        nack,
    output logic        busy,
    i2c_byte_if.master  bus
);

    seq_state_t  state;
    seq_state_t  nxt;
    logic        req;
    logic        wr_byte;   // states that expect a slave ack
    logic        fail;
    logic [10:0] addr_q;
    logic [7:0]  wdata_q;
    logic        rd_q;

    assign req     = (state == IDLE) && (wr || rd);
    assign wr_byte = (state == CTRL_WR) || (state == ADDR) ||
                     (state == DATA_WR) || (state == CTRL_RD);
    assign done    = (state == FINISH);
    assign busy    = (state != IDLE) && (state != FINISH);

    assign bus.tx_nack = 1'b1; // single byte read ends with nack

    always_comb
    begin
        nxt = state;
        case (state)
            IDLE:    if (req) nxt = START;
            START:   if (bus.op_done) nxt = CTRL_WR;
            CTRL_WR: if (bus.op_done) nxt = bus.ack_ok ? ADDR : STOP;
            ADDR:
            begin
                if (bus.op_done)
                    nxt = !bus.ack_ok ? STOP : (rd_q ? RESTART : DATA_WR);
            end
            DATA_WR: if (bus.op_done) nxt = STOP;
            RESTART: if (bus.op_done) nxt = CTRL_RD;
            CTRL_RD: if (bus.op_done) nxt = bus.ack_ok ? DATA_RD : STOP;
            DATA_RD: if (bus.op_done) nxt = STOP;
            STOP:    if (bus.op_done) nxt = FINISH;
            default: nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= IDLE;
            bus.op_valid <= 1'b0;
            fail         <= 1'b0;
            nack         <= 1'b0;
            rdata        <= 8'h00;
        end
        else
        begin
            state        <= nxt;
            bus.op_valid <= (nxt != state) && (nxt != IDLE) && (nxt != FINISH);
            if (req)
            begin
                fail <= 1'b0;
                nack <= 1'b0;
            end
            if (wr_byte && bus.op_done && !bus.ack_ok)
                fail <= 1'b1;
            if ((state == STOP) && bus.op_done)
                nack <= fail;              // shows up with done
            if ((state == DATA_RD) && bus.op_done)
                rdata <= bus.rx_byte;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req)
        begin
            addr_q  <= addr;
            wdata_q <= wdata;
            rd_q    <= !wr;   // wr wins
        end
        if (nxt != state)
        begin
            case (nxt)
                START, RESTART: bus.op <= OP_START;
                STOP:           bus.op <= OP_STOP;
                DATA_RD:        bus.op <= OP_READ;
                default:        bus.op <= OP_WRITE;
            endcase
            case (nxt)
                CTRL_WR: bus.tx_byte <= {DEV_CODE, addr_q[10:8], 1'b0};
                ADDR:    bus.tx_byte <= addr_q[7:0];
                DATA_WR: bus.tx_byte <= wdata_q;
                CTRL_RD: bus.tx_byte <= {DEV_CODE, addr_q[10:8], 1'b1};
                default: bus.tx_byte <= 8'hff;
            endcase
        end
    end

endmodule

//--- eeprom_i2c_top.sv
`timescale 1ns/1ps

module eeprom_i2c_top import eeprom_pkg::*;
#(
    parameter int unsigned CLK_DIV = 4  // clocks per quarter scl period
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wr,
    input  logic        rd,
    input  logic [10:0] addr,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    output logic        done,
    output logic        nack,
    output logic        busy,
    output logic        scl,
    output logic        sda_pull,
    input  logic        sda_in
);

    i2c_byte_if byte_bus ();

    logic     cmd_valid;
    bit_cmd_t cmd;
    logic     cmd_bit;
    logic     bit_done;
    logic     rx_bit;

    eeprom_ctrl u_ctrl (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .done   (done),
        .nack   (nack),
        .busy   (busy),
        .bus    (byte_bus.master)
    );

    i2c_byte_shifter u_shifter (
        .CLK       (CLK),
        .RESET     (RESET),
        .bus       (byte_bus.slave),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bit   (cmd_bit),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_bit   (cmd_bit),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit),
        .scl       (scl),
        .sda_pull  (sda_pull),
        .sda_in    (sda_in)
    );

endmodule

//--- eeprom_model.sv
`timescale 1ns/1ps

module eeprom_model import eeprom_pkg::*;
(
    input  logic scl,
    input  logic sda,         // resolved bus level
    input  logic ack_enable,  // low refuses every acknowledge
    output logic sda_pull
);

    typedef enum logic [2:0] { M_IDLE, M_CTRL, M_ADDR, M_DATA, M_READ } mode_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode;
    logic [3:0]  cnt;        // 0..7 data, 8 ack slot, 9 after ack
    logic [7:0]  shreg;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic [7:0]  wbuf;
    logic        have_data;
    logic        scl_q;
    logic        sda_q;

    task take_byte;
        if (!ack_enable)
            mode = M_IDLE;
        else
        begin
            case (mode)
                M_CTRL:
                begin
                    if (shreg[7:4] == DEV_CODE)
                    begin
                        blk      = shreg[3:1];
                        mode     = shreg[0] ? M_READ : M_ADDR;
                        sda_pull = 1'b1;
                    end
                    else
                        mode = M_IDLE;  // not addressed
                end
                M_ADDR:
                begin
                    ptr      = {blk, shreg};
                    mode     = M_DATA;
                    sda_pull = 1'b1;
                end
                default:
                begin
                    wbuf      = shreg;
                    have_data = 1'b1;
                    sda_pull  = 1'b1;
                end
            endcase
        end
    endtask

    task scl_rise;
        if (mode != M_IDLE)
        begin
            if ((cnt < 4'd8) && (mode != M_READ))
                shreg = {shreg[6:0], sda};
            if ((cnt == 4'd8) && (mode == M_READ) && (sda === 1'b1))
                mode = M_IDLE;  // master nack ends the read
            cnt = cnt + 4'd1;
        end
    endtask

    task scl_fall;
        if (cnt == 4'd9)
        begin
            cnt      = 4'd0;
            sda_pull = 1'b0;
            if (mode == M_READ)
            begin
                shreg    = mem[ptr];
                ptr      = ptr + 11'd1;
                sda_pull = !shreg[7];
            end
        end
        else if (cnt == 4'd8)
        begin
            if (mode == M_READ)
                sda_pull = 1'b0;  // master ack slot
            else if (mode != M_IDLE)
                take_byte();
        end
        else if ((mode == M_READ) && (cnt != 4'd0))
        begin
            shreg    = {shreg[6:0], 1'b1};
            sda_pull = !shreg[7];
        end
    endtask

    initial
    begin
        mem       = '{default: 8'hff};
        mode      = M_IDLE;
        cnt       = 4'd0;
        shreg     = 8'h00;
        blk       = 3'd0;
        ptr       = 11'd0;
        wbuf      = 8'h00;
        have_data = 1'b0;
        sda_pull  = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        forever
        begin
            @(scl or sda);
            if (scl !== scl_q)
            begin
                if (scl === 1'b1)
                    scl_rise();
                else
                    scl_fall();
            end
            else if ((scl === 1'b1) && (sda !== sda_q))
            begin
                if (sda === 1'b0)
                begin
                    // start or repeated start
                    mode      = M_CTRL;
                    cnt       = 4'd0;
                    have_data = 1'b0;
                end
                else
                begin
                    if (have_data)
                        mem[ptr] = wbuf;  // write cycle at stop
                    have_data = 1'b0;
                    mode      = M_IDLE;
                    sda_pull  = 1'b0;
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

//--- eeprom_pkg.sv
package eeprom_pkg;

    // operations the byte shifter accepts
    typedef enum logic [1:0]
    {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } byte_op_t;

    // single bit-time commands for the bit engine
    typedef enum logic [1:0]
    {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_cmd_t;

    typedef enum logic [3:0]
    {
        IDLE, START, CTRL_WR, ADDR, DATA_WR,
        RESTART, CTRL_RD, DATA_RD, STOP, FINISH
    } seq_state_t;

    localparam logic [3:0] DEV_CODE = 4'b1010; // 24cxx device type

endpackage

//--- i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine import eeprom_pkg::*;
#(
    parameter int unsigned CLK_DIV = 4
)
(
    input  logic     CLK,
    input  logic     RESET,
    input  logic     cmd_valid,
    input  bit_cmd_t cmd,
    input  logic     cmd_bit,
    output logic     bit_done,
    output logic     rx_bit,
    output logic     scl,
    output logic     sda_pull,
    input  logic     sda_in
);

    localparam int unsigned QW = $clog2(CLK_DIV);
    localparam logic [QW-1:0] QMAX = QW'(CLK_DIV - 1);

    logic          active;
    logic [QW-1:0] qcnt;     // clocks within a quarter
    logic [1:0]    phase;    // quarter of the bit time
    bit_cmd_t      cur_cmd;
    logic          cur_bit;
    logic          q_end;
    logic          accept;

    assign q_end    = active && (qcnt == QMAX);
    assign bit_done = q_end && (phase == 2'd3);
    assign accept   = cmd_valid && (!active || bit_done); // back to back allowed

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            qcnt     <= '0;
            phase    <= 2'd0;
            scl      <= 1'b1;
            sda_pull <= 1'b0;
        end
        else if (accept)
        begin
            active <= 1'b1;
            qcnt   <= '0;
            phase  <= 2'd0;
            scl    <= 1'b0;
        end
        else if (q_end)
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            case (phase)
                2'd0: // data changes while scl is low
                    sda_pull <= (cur_cmd == BIT_STOP) ||
                                ((cur_cmd == BIT_WRITE) && !cur_bit);
                2'd1:
                    scl <= 1'b1;
                2'd2:
                begin
                    if (cur_cmd == BIT_START)
                        sda_pull <= 1'b1;  // sda falls under a high scl
                    else if (cur_cmd == BIT_STOP)
                        sda_pull <= 1'b0;  // sda rises under a high scl
                end
                default:
                    active <= 1'b0;        // scl stays high
            endcase
        end
        else if (active)
        begin
            qcnt <= qcnt + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            cur_cmd <= cmd;
            cur_bit <= cmd_bit;
        end
        if (q_end && (phase == 2'd2))
            rx_bit <= sda_in; // middle of the high time
    end

endmodule

//--- i2c_byte_if.sv
`timescale 1ns/1ps

interface i2c_byte_if import eeprom_pkg::*; ();

    logic       op_valid;
    byte_op_t   op;
    logic [7:0] tx_byte;
    logic       tx_nack;  // ack bit sent after a read byte
    logic       op_done;
    logic [7:0] rx_byte;
    logic       ack_ok;   // slave pulled sda low in the ack slot

    modport master (
        output op_valid, op, tx_byte, tx_nack,
        input  op_done, rx_byte, ack_ok
    );

    modport slave (
        input  op_valid, op, tx_byte, tx_nack,
        output op_done, rx_byte, ack_ok
    );

endinterface

//--- i2c_byte_shifter.sv
`timescale 1ns/1ps

module i2c_byte_shifter import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    i2c_byte_if.slave  bus,
    output logic       cmd_valid,
    output bit_cmd_t   cmd,
    output logic       cmd_bit,
    input  logic       bit_done,
    input  logic       rx_bit
);

    logic       active;
    byte_op_t   op_q;
    logic [3:0] slot;     // 0..7 data, 8 ack
    logic [7:0] shreg;
    logic       nack_q;
    logic       last;

    byte_op_t   nxt_op;
    logic [3:0] nxt_slot;
    logic [7:0] nxt_sh;
    logic       nxt_nack;

    assign last = (op_q == OP_START) || (op_q == OP_STOP) || (slot == 4'd8);

    // next slot goes out in the same cycle the previous bit ends
    assign cmd_valid = bus.op_valid || (active && bit_done && !last);

    always_comb
    begin
        if (bus.op_valid)
        begin
            nxt_op   = bus.op;
            nxt_slot = 4'd0;
            nxt_sh   = bus.tx_byte;
            nxt_nack = bus.tx_nack;
        end
        else
        begin
            nxt_op   = op_q;
            nxt_slot = slot + 4'd1;
            nxt_sh   = {shreg[6:0], rx_bit};
            nxt_nack = nack_q;
        end

        case (nxt_op)
            OP_START: cmd = BIT_START;
            OP_STOP:  cmd = BIT_STOP;
            OP_WRITE: cmd = (nxt_slot == 4'd8) ? BIT_READ : BIT_WRITE;
            default:  cmd = (nxt_slot == 4'd8) ? BIT_WRITE : BIT_READ;
        endcase
    end

    assign cmd_bit = (nxt_op == OP_WRITE) ? nxt_sh[7] : nxt_nack; // msb first

    assign bus.op_done = active && bit_done && last;
    assign bus.rx_byte = shreg;
    assign bus.ack_ok  = !rx_bit;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            active <= 1'b0;
        else if (bus.op_valid)
            active <= 1'b1;
        else if (bus.op_done)
            active <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid)
        begin
            op_q   <= nxt_op;
            slot   <= nxt_slot;
            shreg  <= nxt_sh;
            nack_q <= nxt_nack;
        end
    end

endmodule

//--- tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom;

    localparam int TIMEOUT = 3000;  // max cycles per wait

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic [7:0]  rdata;
    logic        done;
    logic        nack;
    logic        busy;
    logic        scl;
    logic        sda_pull;
    logic        model_pull;
    logic        sda;
    logic        ack_enable;

    int          errors;
    int          checks;
    logic [7:0]  shadow [0:2047];  // what the bus should hold
    logic        written [0:2047];
    logic [7:0]  rd_val;
    logic        rd_nack;

    assign sda = !(sda_pull || model_pull);  // wired-and with pull-up

    eeprom_i2c_top #(
        .CLK_DIV (4)
    ) u_eeprom_i2c_top (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .done     (done),
        .nack     (nack),
        .busy     (busy),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda)
    );

    eeprom_model u_model (
        .scl        (scl),
        .sda        (sda),
        .ack_enable (ack_enable),
        .sda_pull   (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t ns: %s: got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic pulse_request(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        wr    = is_wr;
        rd    = !is_wr;
        addr  = a;
        wdata = d;
        @(posedge CLK);
        #2;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done;
        int n;
        n = 0;
        while ((done !== 1'b1) && (n < TIMEOUT))
        begin
            @(posedge CLK);
            #2;
            n++;
        end
        if (done !== 1'b1)
        begin
            errors++;
            $display("timeout: done did not come within %0d cycles", TIMEOUT);
        end
        rd_val  = rdata;
        rd_nack = nack;
        @(posedge CLK);  // back in idle
        #2;
    endtask

    task automatic write_word(input logic [10:0] a, input logic [7:0] d);
        pulse_request(1'b1, a, d);
        wait_done();
        check($sformatf("nack after write to %h", a), 32'(rd_nack), 32'd0);
        shadow[a]  = d;
        written[a] = 1'b1;
    endtask

    task automatic read_word(input logic [10:0] a, input logic [7:0] exp);
        pulse_request(1'b0, a, 8'h00);
        wait_done();
        check($sformatf("nack after read of %h", a), 32'(rd_nack), 32'd0);
        check($sformatf("read data at %h", a), 32'(rd_val), 32'(exp));
    endtask

    task automatic idle_after_reset;
        check("scl after reset", 32'(scl), 32'd1);
        check("sda_pull after reset", 32'(sda_pull), 32'd0);
        check("busy after reset", 32'(busy), 32'd0);
        check("done after reset", 32'(done), 32'd0);
        check("nack after reset", 32'(nack), 32'd0);
        check("rdata after reset", 32'(rdata), 32'd0);
    endtask

    task automatic write_then_read;
        write_word(11'h123, 8'h5a);
        read_word(11'h123, 8'h5a);
    endtask

    task automatic cover_all_blocks;
        logic [10:0] addrs [$];
        logic [10:0] a;
        logic [7:0]  low;
        logic [2:0]  b0;
        low = 8'($urandom);
        b0  = 3'($urandom);
        // same word address in five blocks, so only addr[10:8] tells them apart
        for (int i = 0; i < 5; i++)
        begin
            a = {b0 + 3'(i), low};
            addrs.push_back(a);
            write_word(a, 8'($urandom));
        end
        foreach (addrs[j])
            read_word(addrs[j], shadow[addrs[j]]);
    endtask

    task automatic read_unwritten;
        logic [10:0] a;
        a = 11'h7ff;
        while (written[a])
            a = a - 11'd1;
        read_word(a, 8'hff);  // erased state
    endtask

    task automatic refused_write;
        ack_enable = 1'b0;
        pulse_request(1'b1, 11'h123, ~shadow[11'h123]);
        wait_done();
        check("nack after refused write", 32'(rd_nack), 32'd1);
        check("scl after refused write", 32'(scl), 32'd1);
        check("sda_pull after refused write", 32'(sda_pull), 32'd0);
        ack_enable = 1'b1;
        read_word(11'h123, shadow[11'h123]);
    endtask

    task automatic request_while_busy;
        logic [10:0] a_first;
        logic [10:0] a_second;
        logic [7:0]  d_first;
        int          n;
        a_first  = 11'h2a0;
        a_second = 11'h4f5;
        d_first  = 8'($urandom);
        pulse_request(1'b1, a_first, d_first);
        n = 0;
        while ((busy !== 1'b1) && (n < TIMEOUT))
        begin
            @(posedge CLK);
            #2;
            n++;
        end
        if (busy !== 1'b1)
        begin
            errors++;
            $display("timeout: busy did not rise after a write request");
        end
        pulse_request(1'b1, a_second, ~shadow[a_second]);  // dropped
        wait_done();
        check("nack after busy write", 32'(rd_nack), 32'd0);
        shadow[a_first]  = d_first;
        written[a_first] = 1'b1;
        read_word(a_second, shadow[a_second]);
        read_word(a_first, d_first);
    endtask

    initial
    begin
        void'($urandom(86));
        errors     = 0;
        checks     = 0;
        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = 11'd0;
        wdata      = 8'd0;
        ack_enable = 1'b1;
        shadow     = '{default: 8'hff};
        written    = '{default: 1'b0};
        repeat (5) @(posedge CLK);
        #2;
        RESET = 1'b0;

        idle_after_reset();
        write_then_read();
        cover_all_blocks();
        read_unwritten();
        refused_write();
        request_while_busy();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule
